// File: hw/switch_pkg.sv
// Switch package with port constants and the packed structs shared by all blocks
package switch_pkg;

  localparam int NUM_PORTS       = 4;
  localparam int PORT_BITS       = 2;
  localparam int BYTE_BITS       = 8;
  localparam int MAC_BITS        = 48;
  localparam int HDR_BYTES       = 12;
  localparam int FLOW_ENTRIES    = 8;
  localparam int IFG_CYCLES      = 12;
  localparam int RX_QUEUE_LOG2   = 8;
  localparam int XBAR_QUEUE_LOG2 = 6;

  // One stored byte, last marks the end of a frame
  typedef struct packed {
    logic                 last;
    logic [BYTE_BITS-1:0] data;
  } queue_word_t;

  typedef struct packed {
    logic [BYTE_BITS-1:0] rxd;
    logic                 rx_dv;
  } gmii_rx_t;

  typedef struct packed {
    logic [BYTE_BITS-1:0] txd;
    logic                 tx_en;
  } gmii_tx_t;

  typedef logic [NUM_PORTS-1:0] port_mask_t;

  typedef struct packed {
    logic                req;
    logic [MAC_BITS-1:0] dst_mac;
    logic [MAC_BITS-1:0] src_mac;
  } lookup_req_t;

  typedef struct packed {
    logic       ack;
    port_mask_t fwd_mask;
  } lookup_resp_t;

endpackage

// File: hw/sync_fifo.sv
// Single-clock queue of 9-bit words with full and empty flags
`timescale 1ns/10ps

module sync_fifo
  import switch_pkg::*;
#(
  parameter int DEPTH_LOG2 = RX_QUEUE_LOG2
) (
    input  logic        sys_clk
  , input  logic        rst_n
  , input  queue_word_t din
  , input  logic        wr_en
  , output logic        full
  , output queue_word_t dout
  , input  logic        rd_en
  , output logic        empty
);

  queue_word_t           mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  // Count reaches 2**DEPTH_LOG2 only when every slot is used
  assign full  = count[DEPTH_LOG2];
  assign empty = count == '0;
  assign dout  = mem[rd_ptr];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

endmodule

// File: hw/gmii_rx_framer.sv
// GMII receive framing into queue words with last-byte marking and frame drop
`timescale 1ns/10ps

module gmii_rx_framer
  import switch_pkg::*;
(
    input  logic        sys_clk
  , input  logic        rst_n
  , input  gmii_rx_t    gmii_rx
  , output queue_word_t din
  , output logic        wr_en
  , input  logic        full
);

  logic [BYTE_BITS-1:0] hold;
  logic                 hold_valid;
  logic                 in_frame;
  logic                 cut;
  logic                 discard;
  logic                 first;
  logic                 blocked;
  logic                 refuse;
  logic                 take;

  assign first   = gmii_rx.rx_dv & ~in_frame;
  assign blocked = hold_valid & full;
  // Refused at start when no room, or a cut frame still waits for its end byte
  assign refuse  = first & (full | hold_valid);
  assign take    = gmii_rx.rx_dv & ~discard & ~cut & ~blocked & ~refuse;

  // Held byte goes out once the next byte or the end of frame is seen
  assign wr_en = hold_valid & ~full;
  assign din   = '{last: cut | ~gmii_rx.rx_dv, data: hold};

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
      in_frame   <= 1'b0;
      cut        <= 1'b0;
      discard    <= 1'b0;
    end else begin
      in_frame <= gmii_rx.rx_dv;
      if (take) hold_valid <= 1'b1;
      else if (wr_en) hold_valid <= 1'b0;
      // Queue full with a byte pending, so that byte becomes the frame end
      if (blocked) cut <= 1'b1;
      else if (wr_en) cut <= 1'b0;
      if (refuse || (blocked && gmii_rx.rx_dv)) discard <= 1'b1;
      else if (!gmii_rx.rx_dv) discard <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (take) hold <= gmii_rx.rxd;
  end

endmodule

// File: hw/flow_lookup.sv
// Shared MAC learning table answering forwarder lookups by fixed priority
`timescale 1ns/10ps

module flow_lookup
  import switch_pkg::*;
(
    input  logic         sys_clk
  , input  logic         rst_n
  , input  lookup_req_t  lookup_req  [NUM_PORTS]
  , output lookup_resp_t lookup_resp [NUM_PORTS]
);

  typedef logic [$clog2(FLOW_ENTRIES)-1:0] entry_idx_t;

  logic [MAC_BITS-1:0]     entry_mac  [FLOW_ENTRIES];
  logic [PORT_BITS-1:0]    entry_port [FLOW_ENTRIES];
  logic [FLOW_ENTRIES-1:0] entry_valid;
  entry_idx_t              repl_ptr;

  port_mask_t           pending;
  port_mask_t           ack_q;
  port_mask_t           mask_q;
  logic [PORT_BITS-1:0] sel;
  lookup_req_t          cur;
  logic                 dst_hit;
  logic [PORT_BITS-1:0] dst_port;
  logic                 src_hit;
  entry_idx_t           src_idx;
  port_mask_t           mask;
  logic                 learn;

  // ------------------------------
  // Arbitration
  // ------------------------------
  // A port being acked still holds req for that cycle
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      pending[p] = lookup_req[p].req & ~ack_q[p];
    end
  end

  always_comb begin
    sel = '0;
    for (int p = NUM_PORTS - 1; p >= 0; p--) begin
      if (pending[p]) sel = PORT_BITS'(p);
    end
  end

  assign cur = lookup_req[sel];

  // ------------------------------
  // Match and forwarding rule
  // ------------------------------
  always_comb begin
    dst_hit  = 1'b0;
    dst_port = '0;
    src_hit  = 1'b0;
    src_idx  = '0;
    for (int e = 0; e < FLOW_ENTRIES; e++) begin
      if (entry_valid[e] && entry_mac[e] == cur.dst_mac) begin
        dst_hit  = 1'b1;
        dst_port = entry_port[e];
      end
      if (entry_valid[e] && entry_mac[e] == cur.src_mac) begin
        src_hit = 1'b1;
        src_idx = entry_idx_t'(e);
      end
    end
    // Group bit is bit 0 of the first byte on the wire
    if (cur.dst_mac[MAC_BITS-BYTE_BITS] || !dst_hit) mask = '1;
    else mask = port_mask_t'(1) << dst_port;
    mask[sel] = 1'b0;
  end

  assign learn = (|pending) & ~cur.src_mac[MAC_BITS-BYTE_BITS];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q       <= '0;
      entry_valid <= '0;
      repl_ptr    <= '0;
    end else begin
      ack_q <= '0;
      if (|pending) ack_q[sel] <= 1'b1;
      if (learn && !src_hit) begin
        entry_valid[repl_ptr] <= 1'b1;
        repl_ptr              <= repl_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (|pending) mask_q <= mask;
    if (learn) begin
      if (src_hit) begin
        entry_port[src_idx] <= sel;
      end else begin
        entry_mac[repl_ptr]  <= cur.src_mac;
        entry_port[repl_ptr] <= sel;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      lookup_resp[p] = '{ack: ack_q[p], fwd_mask: mask_q};
    end
  end

endmodule

// File: hw/forwarder.sv
// Per-ingress forwarder that collects the header, asks for a lookup and copies the frame out
`timescale 1ns/10ps

module forwarder
  import switch_pkg::*;
#(
  parameter int PORT_NUM = 0
) (
    input  logic         sys_clk
  , input  logic         rst_n
  , input  queue_word_t  rx_dout
  , input  logic         rx_empty
  , output logic         rx_rd_en
  , output lookup_req_t  lookup_req
  , input  lookup_resp_t lookup_resp
  , output queue_word_t  tx_din
  , output port_mask_t   tx_wr_en
  , input  port_mask_t   tx_full
);

  typedef enum logic [2:0] {
    ST_HEADER,
    ST_LOOKUP,
    ST_REPLAY,
    ST_BODY,
    ST_DISCARD
  } state_t;

  typedef logic [$clog2(HDR_BYTES)-1:0] hdr_cnt_t;

  state_t                         state;
  hdr_cnt_t                       hdr_cnt;
  logic [HDR_BYTES*BYTE_BITS-1:0] hdr;
  logic                           hdr_ends;
  port_mask_t                     fwd_mask;
  port_mask_t                     granted;
  logic                           hdr_done;
  logic                           stall;
  logic                           body_go;

  // Lookup already clears the ingress bit
  assign granted  = lookup_resp.fwd_mask;
  assign hdr_done = hdr_cnt == hdr_cnt_t'(HDR_BYTES - 1);
  // Any target queue full holds the whole copy
  assign stall    = |(fwd_mask & tx_full);
  assign body_go  = (state == ST_BODY) & ~rx_empty & ~stall;

  // First received byte sits at the top of the shift register
  assign lookup_req = '{
    req:     state == ST_LOOKUP,
    dst_mac: hdr[HDR_BYTES*BYTE_BITS-1 -: MAC_BITS],
    src_mac: hdr[MAC_BITS-1:0]
  };

  always_comb begin
    rx_rd_en = 1'b0;
    tx_wr_en = '0;
    tx_din   = rx_dout;
    case (state)
      ST_HEADER, ST_DISCARD: begin
        rx_rd_en = ~rx_empty;
      end
      ST_REPLAY: begin
        tx_din.last = hdr_ends & hdr_done;
        tx_din.data = hdr[HDR_BYTES*BYTE_BITS-1 -: BYTE_BITS];
        if (!stall) tx_wr_en = fwd_mask;
      end
      ST_BODY: begin
        rx_rd_en = body_go;
        if (body_go) tx_wr_en = fwd_mask;
      end
      default: begin
        rx_rd_en = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // Frame state machine
  // ------------------------------
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_HEADER;
      hdr_cnt <= '0;
    end else begin
      case (state)
        ST_HEADER: begin
          if (!rx_empty) begin
            if (hdr_done) begin
              hdr_cnt <= '0;
              state   <= ST_LOOKUP;
            end else if (rx_dout.last) begin
              // Runt is dropped before any lookup
              hdr_cnt <= '0;
            end else begin
              hdr_cnt <= hdr_cnt + 1'b1;
            end
          end
        end
        ST_LOOKUP: begin
          if (lookup_resp.ack) begin
            if (granted == '0) state <= hdr_ends ? ST_HEADER : ST_DISCARD;
            else state <= ST_REPLAY;
          end
        end
        ST_REPLAY: begin
          if (!stall) begin
            if (hdr_done) begin
              hdr_cnt <= '0;
              state   <= hdr_ends ? ST_HEADER : ST_BODY;
            end else begin
              hdr_cnt <= hdr_cnt + 1'b1;
            end
          end
        end
        ST_BODY: begin
          if (body_go && rx_dout.last) state <= ST_HEADER;
        end
        ST_DISCARD: begin
          if (!rx_empty && rx_dout.last) state <= ST_HEADER;
        end
        default: begin
          state <= ST_HEADER;
        end
      endcase
    end
  end

  // Header shifts in while collecting and shifts out while replaying
  always_ff @(posedge sys_clk) begin
    if (state == ST_HEADER && !rx_empty) begin
      hdr      <= {hdr[HDR_BYTES*BYTE_BITS-BYTE_BITS-1:0], rx_dout.data};
      hdr_ends <= rx_dout.last;
    end
    if (state == ST_REPLAY && !stall) hdr <= hdr << BYTE_BITS;
    if (state == ST_LOOKUP && lookup_resp.ack) fwd_mask <= granted;
  end

endmodule

// File: hw/mixer.sv
// Egress mixer, round-robin over the ingress queues one whole frame at a time
`timescale 1ns/10ps

module mixer
  import switch_pkg::*;
(
    input  logic        sys_clk
  , input  logic        rst_n
  , input  queue_word_t q_dout [NUM_PORTS]
  , input  port_mask_t  q_empty
  , output port_mask_t  q_rd_en
  , output queue_word_t tx_word
  , output logic        tx_valid
  , input  logic        tx_ready
);

  logic [PORT_BITS-1:0] rr_ptr;
  logic                 busy;
  logic [PORT_BITS-1:0] next_sel;
  logic                 next_found;
  logic                 fire;

  // Nearest non-empty queue after the one last served, itself last
  always_comb begin
    logic [PORT_BITS-1:0] idx;
    next_sel   = rr_ptr;
    next_found = 1'b0;
    for (int off = NUM_PORTS; off >= 1; off--) begin
      idx = rr_ptr + PORT_BITS'(off);
      if (!q_empty[idx]) begin
        next_sel   = idx;
        next_found = 1'b1;
      end
    end
  end

  assign tx_word  = q_dout[rr_ptr];
  assign tx_valid = busy & ~q_empty[rr_ptr];
  assign fire     = tx_valid & tx_ready;

  always_comb begin
    q_rd_en         = '0;
    q_rd_en[rr_ptr] = fire;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= PORT_BITS'(NUM_PORTS - 1);
      busy   <= 1'b0;
    end else if (!busy) begin
      if (next_found) begin
        rr_ptr <= next_sel;
        busy   <= 1'b1;
      end
    end else if (fire && tx_word.last) begin
      // Frame done, queue released
      busy <= 1'b0;
    end
  end

endmodule

// File: hw/gmii_tx_framer.sv
// GMII transmit framing from queue words with the inter-frame gap
`timescale 1ns/10ps

module gmii_tx_framer
  import switch_pkg::*;
(
    input  logic        sys_clk
  , input  logic        rst_n
  , input  queue_word_t tx_word
  , input  logic        tx_valid
  , output logic        tx_ready
  , output gmii_tx_t    gmii_tx
);

  typedef logic [$clog2(IFG_CYCLES + 1)-1:0] gap_cnt_t;

  gap_cnt_t             gap_cnt;
  logic                 tx_en_q;
  logic [BYTE_BITS-1:0] txd_q;
  logic                 accept;

  // Ready stays low for the whole gap
  assign tx_ready = gap_cnt == '0;
  assign accept   = tx_valid & tx_ready;
  assign gmii_tx  = '{txd: txd_q, tx_en: tx_en_q};

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      gap_cnt <= '0;
      tx_en_q <= 1'b0;
    end else begin
      tx_en_q <= accept;
      if (accept && tx_word.last) gap_cnt <= gap_cnt_t'(IFG_CYCLES);
      else if (gap_cnt != '0) gap_cnt <= gap_cnt - 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (accept) txd_q <= tx_word.data;
  end

endmodule

// File: hw/switch_top.sv
// Four-port learning switch top with port slices, crossbar queues and shared lookup
`timescale 1ns/10ps

module switch_top
  import switch_pkg::*;
(
    input  logic     sys_clk
  , input  logic     rst_n
  , input  gmii_rx_t gmii_rx [NUM_PORTS]
  , output gmii_tx_t gmii_tx [NUM_PORTS]
);

  queue_word_t  rx_din      [NUM_PORTS];
  logic         rx_wr_en    [NUM_PORTS];
  logic         rx_full     [NUM_PORTS];
  queue_word_t  rx_dout     [NUM_PORTS];
  logic         rx_rd_en    [NUM_PORTS];
  logic         rx_empty    [NUM_PORTS];
  lookup_req_t  lookup_req  [NUM_PORTS];
  lookup_resp_t lookup_resp [NUM_PORTS];

  // Forwarder side, indexed by ingress then egress bit
  queue_word_t  fwd_din     [NUM_PORTS];
  port_mask_t   fwd_wr_en   [NUM_PORTS];
  wire port_mask_t fwd_full [NUM_PORTS];

  // Mixer side, indexed by egress then ingress
  queue_word_t  xbar_dout   [NUM_PORTS][NUM_PORTS];
  wire port_mask_t xbar_empty [NUM_PORTS];
  port_mask_t   xbar_rd_en  [NUM_PORTS];

  queue_word_t  tx_word     [NUM_PORTS];
  logic         tx_valid    [NUM_PORTS];
  logic         tx_ready    [NUM_PORTS];

  // ------------------------------
  // Port slices
  // ------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    gmii_rx_framer rx_framer (
        .sys_clk(sys_clk)
      , .rst_n(rst_n)
      , .gmii_rx(gmii_rx[p])
      , .din(rx_din[p])
      , .wr_en(rx_wr_en[p])
      , .full(rx_full[p])
    );

    sync_fifo #(
        .DEPTH_LOG2(RX_QUEUE_LOG2)
    ) rx_q (
        .sys_clk(sys_clk)
      , .rst_n(rst_n)
      , .din(rx_din[p])
      , .wr_en(rx_wr_en[p])
      , .full(rx_full[p])
      , .dout(rx_dout[p])
      , .rd_en(rx_rd_en[p])
      , .empty(rx_empty[p])
    );

    forwarder #(
        .PORT_NUM(p)
    ) fwd (
        .sys_clk(sys_clk)
      , .rst_n(rst_n)
      , .rx_dout(rx_dout[p])
      , .rx_empty(rx_empty[p])
      , .rx_rd_en(rx_rd_en[p])
      , .lookup_req(lookup_req[p])
      , .lookup_resp(lookup_resp[p])
      , .tx_din(fwd_din[p])
      , .tx_wr_en(fwd_wr_en[p])
      , .tx_full(fwd_full[p])
    );

    mixer tx_mixer (
        .sys_clk(sys_clk)
      , .rst_n(rst_n)
      , .q_dout(xbar_dout[p])
      , .q_empty(xbar_empty[p])
      , .q_rd_en(xbar_rd_en[p])
      , .tx_word(tx_word[p])
      , .tx_valid(tx_valid[p])
      , .tx_ready(tx_ready[p])
    );

    gmii_tx_framer tx_framer (
        .sys_clk(sys_clk)
      , .rst_n(rst_n)
      , .tx_word(tx_word[p])
      , .tx_valid(tx_valid[p])
      , .tx_ready(tx_ready[p])
      , .gmii_tx(gmii_tx[p])
    );
  end

  // ------------------------------
  // Crossbar queues
  // ------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_ingress
    for (genvar e = 0; e < NUM_PORTS; e++) begin : g_egress
      sync_fifo #(
          .DEPTH_LOG2(XBAR_QUEUE_LOG2)
      ) xbar_q (
          .sys_clk(sys_clk)
        , .rst_n(rst_n)
        , .din(fwd_din[i])
        , .wr_en(fwd_wr_en[i][e])
        , .full(fwd_full[i][e])
        , .dout(xbar_dout[e][i])
        , .rd_en(xbar_rd_en[e][i])
        , .empty(xbar_empty[e][i])
      );
    end
  end

  flow_lookup lookup (
      .sys_clk(sys_clk)
    , .rst_n(rst_n)
    , .lookup_req(lookup_req)
    , .lookup_resp(lookup_resp)
  );

endmodule

// File: verification/switch_tb.sv
// Directed testbench for the four-port learning switch with a reference learning model
`timescale 1ns/10ps

module switch_tb
  import switch_pkg::*;
();

  localparam int MAX_CYCLES   = 20000;
  localparam int QUIET_CYCLES = 100;
  localparam int MAX_EXPECTED = 8;

  localparam logic [MAC_BITS-1:0] MAC_A       = 48'h02_00_00_00_00_0a;
  localparam logic [MAC_BITS-1:0] MAC_B       = 48'h02_00_00_00_00_0b;
  localparam logic [MAC_BITS-1:0] MAC_C       = 48'h02_00_00_00_00_0c;
  localparam logic [MAC_BITS-1:0] MAC_D       = 48'h02_00_00_00_00_0d;
  localparam logic [MAC_BITS-1:0] MAC_E       = 48'h02_00_00_00_00_0e;
  localparam logic [MAC_BITS-1:0] MAC_F       = 48'h02_00_00_00_00_0f;
  localparam logic [MAC_BITS-1:0] MAC_UNKNOWN = 48'h02_00_00_00_00_99;
  localparam logic [MAC_BITS-1:0] MAC_BCAST   = 48'hff_ff_ff_ff_ff_ff;

  logic     sys_clk = 1'b0;
  logic     rst_n;
  gmii_rx_t gmii_rx [NUM_PORTS];
  gmii_tx_t gmii_tx [NUM_PORTS];

  int seed;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // Stimulus and expected egress traffic as flat bytes and frame lengths
  logic [BYTE_BITS-1:0] frame_buf [NUM_PORTS][$];
  logic [BYTE_BITS-1:0] exp_data  [NUM_PORTS][$];
  int                   exp_len   [NUM_PORTS][$];

  // Captured egress traffic
  logic [BYTE_BITS-1:0] cap_data [NUM_PORTS][$];
  int                   cap_len  [NUM_PORTS][$];
  int                   cap_gap  [NUM_PORTS][$];
  int                   cur_len  [NUM_PORTS];
  int                   idle_cnt [NUM_PORTS];

  // Reference learning table
  logic [MAC_BITS-1:0] ref_mac   [FLOW_ENTRIES];
  int                  ref_port  [FLOW_ENTRIES];
  bit                  ref_valid [FLOW_ENTRIES];
  int                  ref_ptr;

  switch_top UUT (
      .sys_clk(sys_clk)
    , .rst_n(rst_n)
    , .gmii_rx(gmii_rx)
    , .gmii_tx(gmii_tx)
  );

  always #50 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // ------------------------------
  // Egress monitors
  // ------------------------------
  always @(negedge sys_clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (gmii_tx[p].tx_en) begin
        if (cur_len[p] == 0) begin
          cap_gap[p].push_back(idle_cnt[p]);
        end
        cap_data[p].push_back(gmii_tx[p].txd);
        cur_len[p]++;
        idle_cnt[p] = 0;
      end else begin
        if (cur_len[p] != 0) begin
          cap_len[p].push_back(cur_len[p]);
          cur_len[p] = 0;
        end
        idle_cnt[p]++;
      end
    end
  end

  // Mask by the forwarding rule and then learn the source
  function automatic port_mask_t predict_mask(input int port, input logic [MAC_BITS-1:0] dst,
                                              input logic [MAC_BITS-1:0] src);
    port_mask_t mask;
    int         dst_entry;
    int         src_entry;
    dst_entry = -1;
    src_entry = -1;
    for (int e = 0; e < FLOW_ENTRIES; e++) begin
      if (ref_valid[e] && ref_mac[e] == dst) dst_entry = e;
      if (ref_valid[e] && ref_mac[e] == src) src_entry = e;
    end
    // Group bit of the first byte on the wire
    if (dst[40] || dst_entry < 0) begin
      mask = '1;
    end else begin
      mask = port_mask_t'(1) << ref_port[dst_entry];
    end
    mask[port] = 1'b0;
    if (!src[40]) begin
      if (src_entry >= 0) begin
        ref_port[src_entry] = port;
      end else begin
        ref_mac[ref_ptr]   = src;
        ref_port[ref_ptr]  = port;
        ref_valid[ref_ptr] = 1'b1;
        ref_ptr            = (ref_ptr + 1) % FLOW_ENTRIES;
      end
    end
    return mask;
  endfunction

  task automatic prepare_frame(input int port, input logic [MAC_BITS-1:0] dst,
                               input logic [MAC_BITS-1:0] src, input int len);
    port_mask_t mask;
    frame_buf[port].delete();
    for (int i = 0; i < 6; i++) begin
      frame_buf[port].push_back(dst[MAC_BITS-1-8*i -: 8]);
    end
    for (int i = 0; i < 6; i++) begin
      frame_buf[port].push_back(src[MAC_BITS-1-8*i -: 8]);
    end
    while (frame_buf[port].size() < len) begin
      frame_buf[port].push_back(8'($random(seed)));
    end
    while (frame_buf[port].size() > len) begin
      void'(frame_buf[port].pop_back());
    end
    // Runts never reach the lookup
    if (len >= HDR_BYTES) begin
      mask = predict_mask(port, dst, src);
      for (int e = 0; e < NUM_PORTS; e++) begin
        if (mask[e]) begin
          for (int i = 0; i < len; i++) begin
            exp_data[e].push_back(frame_buf[port][i]);
          end
          exp_len[e].push_back(len);
        end
      end
    end
  endtask

  task automatic send_frame(input int port);
    for (int i = 0; i < frame_buf[port].size(); i++) begin
      @(negedge sys_clk);
      gmii_rx[port] = '{rxd: frame_buf[port][i], rx_dv: 1'b1};
    end
    @(negedge sys_clk);
    gmii_rx[port] = '{rxd: '0, rx_dv: 1'b0};
  endtask

  function automatic bit any_tx_en();
    bit busy;
    busy = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (gmii_tx[p].tx_en) busy = 1'b1;
    end
    return busy;
  endfunction

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(negedge sys_clk);
      if (any_tx_en()) quiet = 0;
      else quiet++;
    end
  endtask

  task automatic clear_captures();
    for (int p = 0; p < NUM_PORTS; p++) begin
      cap_data[p].delete();
      cap_len[p].delete();
      cap_gap[p].delete();
      exp_data[p].delete();
      exp_len[p].delete();
    end
  endtask

  function automatic bit frame_match(input int p, input int k, input int j);
    int co;
    int eo;
    co = 0;
    eo = 0;
    for (int i = 0; i < k; i++) co += cap_len[p][i];
    for (int i = 0; i < j; i++) eo += exp_len[p][i];
    if (cap_len[p][k] != exp_len[p][j]) return 1'b0;
    for (int i = 0; i < exp_len[p][j]; i++) begin
      if (cap_data[p][co + i] != exp_data[p][eo + i]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Frames on one port may come in any order and each must match one expected frame
  task automatic compare_ports();
    bit found;
    bit used [MAX_EXPECTED];
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int j = 0; j < MAX_EXPECTED; j++) used[j] = 1'b0;
      checks++;
      if (cap_len[p].size() != exp_len[p].size()) begin
        errors++;
        $display("FAILED at %0t: port %0d sent %0d frames, expected %0d",
                 $time, p, cap_len[p].size(), exp_len[p].size());
      end
      for (int k = 0; k < cap_len[p].size(); k++) begin
        found = 1'b0;
        for (int j = 0; j < exp_len[p].size() && j < MAX_EXPECTED; j++) begin
          if (!found && !used[j] && frame_match(p, k, j)) begin
            used[j] = 1'b1;
            found   = 1'b1;
          end
        end
        checks++;
        if (!found) begin
          errors++;
          $display("FAILED at %0t: port %0d frame %0d of %0d bytes matches no expected frame",
                   $time, p, k, cap_len[p][k]);
        end
        checks++;
        if (k > 0 && cap_gap[p][k] < IFG_CYCLES) begin
          errors++;
          $display("FAILED at %0t: port %0d gap of %0d idle cycles before frame %0d",
                   $time, p, cap_gap[p][k], k);
        end
      end
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic idle_after_reset();
    @(negedge sys_clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      checks++;
      if (gmii_tx[p].tx_en !== 1'b0) begin
        errors++;
        $display("FAILED at %0t: tx_en high on port %0d after reset", $time, p);
      end
    end
  endtask

  task automatic flood_unknown_unicast();
    clear_captures();
    prepare_frame(0, MAC_UNKNOWN, MAC_A, 40);
    send_frame(0);
    wait_idle();
    compare_ports();
  endtask

  task automatic forward_learned_unicast();
    clear_captures();
    prepare_frame(2, MAC_A, MAC_B, 40);
    send_frame(2);
    // Destination lives on the ingress port so nothing goes out
    prepare_frame(0, MAC_A, MAC_C, 40);
    send_frame(0);
    wait_idle();
    compare_ports();
  endtask

  task automatic broadcast_from_port3();
    clear_captures();
    prepare_frame(3, MAC_BCAST, MAC_D, 40);
    send_frame(3);
    wait_idle();
    compare_ports();
  endtask

  task automatic merge_simultaneous_frames();
    clear_captures();
    prepare_frame(1, MAC_A, MAC_E, 60);
    prepare_frame(2, MAC_A, MAC_F, 60);
    fork
      send_frame(1);
      send_frame(2);
    join
    wait_idle();
    compare_ports();
  endtask

  task automatic drop_runt_frame();
    clear_captures();
    prepare_frame(1, MAC_A, MAC_E, 8);
    send_frame(1);
    prepare_frame(1, MAC_B, MAC_E, 40);
    send_frame(1);
    wait_idle();
    compare_ports();
  endtask

  initial begin
    seed  = 18;
    rst_n = 1'b0;
    ref_ptr = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      gmii_rx[p]  = '{rxd: '0, rx_dv: 1'b0};
      cur_len[p]  = 0;
      idle_cnt[p] = 0;
    end
    for (int e = 0; e < FLOW_ENTRIES; e++) ref_valid[e] = 1'b0;
    repeat (3) @(negedge sys_clk);
    rst_n = 1'b1;

    idle_after_reset();
    flood_unknown_unicast();
    forward_learned_unicast();
    broadcast_from_port3();
    merge_simultaneous_frames();
    drop_runt_frame();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/switch_pkg.sv
hw/sync_fifo.sv
hw/gmii_rx_framer.sv
hw/flow_lookup.sv
hw/forwarder.sv
hw/mixer.sv
hw/gmii_tx_framer.sv
hw/switch_top.sv
verification/switch_tb.sv

// File: Makefile
# Verilator build and run of the switch testbench

TOP = switch_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
		--top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
